//--- rtl/scurve_settings.svh
`ifndef SCURVE_SETTINGS_SVH
`define SCURVE_SETTINGS_SVH

////////////////////
// DAC sweep
////////////////////

// First and last threshold code, both inclusive
`define SCURVE_DAC_FIRST 10'd100
`define SCURVE_DAC_LAST 10'd130
// Code increment between two points
`define SCURVE_DAC_STEP 10'd10

////////////////////
// Stream markers
////////////////////

// Channel number goes into the low byte
`define SCURVE_CHN_HEADER 16'hFF00
// Closes the stream of one test
`define SCURVE_TAIL_WORD 16'hFF45

// Count FIFO entries
`define SCURVE_FIFO_DEPTH 16

`endif

//--- rtl/microroc_sc_pkg.sv
package microroc_sc_pkg;

    ////////////////////
    // Charge injection
    ////////////////////

    // Test capacitor or the preamp input pin
    typedef enum logic {
        inject_ctest,
        inject_input
    } inject_mode_e;

    ////////////////////
    // Slow-control word
    ////////////////////

    // Part of the chip config that the S-curve engine owns
    // 266 bits, upper field first
    typedef struct packed {
        // Test-capacitor switch, one bit per channel
        logic [63:0]  ctest_chn;
        // Threshold DAC
        logic [9:0]   dac_code;
        // Three discriminator enables per channel
        // Channel n at bits 3n+2 down to 3n
        logic [191:0] discri_mask;
    } sc_config_t;

endpackage

//--- rtl/scurve_test_pkg.sv
package scurve_test_pkg;

    ////////////////////
    // Test parameters
    ////////////////////

    // Captured once, at the start edge
    typedef struct packed {
        // Channel under test in single mode
        logic [5:0]                  single_chn;
        // Walk channels 0 to 63 when set
        logic                        all_channels;
        // Injection path
        microroc_sc_pkg::inject_mode_e inject;
        // Window length in clk_ext periods
        logic [15:0]                 cpt_max;
    } test_param_t;

    ////////////////////
    // State machines
    ////////////////////

    // Sequencer over channels and DAC points
    typedef enum logic [3:0] {
        ctrl_idle,
        ctrl_clear,
        ctrl_load,
        ctrl_wait_config,
        ctrl_measure,
        ctrl_forward,
        ctrl_tail,
        ctrl_wait_transmit,
        ctrl_done
    } ctrl_state_e;

    // One counting window
    typedef enum logic [1:0] {
        meas_idle,
        meas_arm,
        meas_count
    } meas_state_e;

endpackage

//--- rtl/scurve_data_fifo.sv
`timescale 1ns/1ps
`include "scurve_settings.svh"

module scurve_data_fifo (
    input  logic        Clk,
    input  logic        reset_n,
    input  logic        clear,
    input  logic        wr_en,
    input  logic [15:0] din,
    input  logic        rd_en,
    output logic [15:0] dout,
    output logic        empty,
    output logic        full
);
    localparam int DEPTH = `SCURVE_FIFO_DEPTH;
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [15:0]   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_write;
    logic          do_read;

    // Overflow writes and underflow reads are dropped
    assign do_write = wr_en & ~full;
    assign do_read  = rd_en & ~empty;

    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));
    // Fall-through head word
    assign dout  = mem[rd_ptr];

    // Storage
    always_ff @(posedge Clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keep the count
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rtl/scurve_single_test.sv
`timescale 1ns/1ps

module scurve_single_test import scurve_test_pkg::*; (
    input  logic        Clk,
    input  logic        reset_n,
    input  logic        clk_ext,
    input  logic [2:0]  trigger_n,
    input  logic        single_test_start,
    input  logic [15:0] cpt_max,
    output logic [15:0] count_data,
    output logic        count_wr_en,
    output logic        single_test_done
);
    meas_state_e state;

    logic [2:0]  clk_ext_sync;
    logic [2:0]  trig_meta;
    logic [2:0]  trig_sync;
    logic        trig_all_d;
    logic        ext_rise;
    logic        trig_fall;
    logic [15:0] cpt_limit;
    logic [15:0] period_cnt;
    logic [15:0] period_next;
    logic [15:0] event_cnt;
    logic [15:0] event_next;

    ////////////////////
    // Synchronizers
    ////////////////////

    // Two flops into Clk, third one for edge detect
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            clk_ext_sync <= '0;
            // Trigger lines idle high
            trig_meta    <= '1;
            trig_sync    <= '1;
            trig_all_d   <= 1'b1;
        end else begin
            clk_ext_sync <= {clk_ext_sync[1:0], clk_ext};
            trig_meta    <= trigger_n;
            trig_sync    <= trig_meta;
            trig_all_d   <= &trig_sync;
        end
    end

    assign ext_rise  = clk_ext_sync[1] & ~clk_ext_sync[2];
    // Any line going low pulls the AND down
    assign trig_fall = trig_all_d & ~(&trig_sync);

    // Saturating event count
    assign event_next  = (trig_fall && event_cnt != 16'hFFFF) ? event_cnt + 1'b1 : event_cnt;
    assign period_next = period_cnt + 1'b1;

    ////////////////////
    // Window FSM
    ////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state            <= meas_idle;
            cpt_limit        <= '0;
            period_cnt       <= '0;
            event_cnt        <= '0;
            count_data       <= '0;
            count_wr_en      <= 1'b0;
            single_test_done <= 1'b0;
        end else begin
            count_wr_en      <= 1'b0;
            single_test_done <= 1'b0;
            case (state)
                meas_idle: begin
                    if (single_test_start) begin
                        cpt_limit  <= cpt_max;
                        period_cnt <= '0;
                        event_cnt  <= '0;
                        state      <= meas_arm;
                    end
                end
                // Wait for first clk_ext rise to open the window
                meas_arm: begin
                    if (ext_rise) begin
                        if (cpt_limit == '0) begin
                            // Zero-length window
                            count_data       <= event_cnt;
                            count_wr_en      <= 1'b1;
                            single_test_done <= 1'b1;
                            state            <= meas_idle;
                        end else begin
                            state <= meas_count;
                        end
                    end
                end
                meas_count: begin
                    event_cnt <= event_next;
                    if (ext_rise) begin
                        period_cnt <= period_next;
                        // Close after cpt_max further rises
                        if (period_next == cpt_limit) begin
                            count_data       <= event_next;
                            count_wr_en      <= 1'b1;
                            single_test_done <= 1'b1;
                            state            <= meas_idle;
                        end
                    end
                end
                default: state <= meas_idle;
            endcase
        end
    end

endmodule

//--- rtl/scurve_test_control.sv
`timescale 1ns/1ps
`include "scurve_settings.svh"

module scurve_test_control import microroc_sc_pkg::*, scurve_test_pkg::*; (
    input  logic        Clk,
    input  logic        reset_n,
    input  logic        test_start,
    input  test_param_t test_param,
    input  logic        microroc_config_done,
    input  logic        data_transmit_done,
    input  logic        single_test_done,
    input  logic        fifo_empty,
    input  logic [15:0] fifo_dout,
    output logic        single_test_start,
    output logic [15:0] cpt_max,
    output logic        fifo_clear,
    output logic        fifo_rd_en,
    output logic        sc_param_load,
    output sc_config_t  sc_config,
    output logic        usb_wr_en,
    output logic [15:0] usb_wr_data,
    output logic        scurve_test_done
);
    ctrl_state_e state;
    test_param_t param_q;

    logic        start_d1;
    logic        start_d2;
    logic        start_pulse;
    logic [5:0]  chn;
    logic [9:0]  dac_code;
    logic [10:0] dac_next;
    logic        last_point;
    logic        last_chn;
    logic        point_done;

    // Config word for one channel and one DAC point
    function automatic sc_config_t build_config(input logic [5:0] ch,
                                                input logic [9:0] dac,
                                                input test_param_t p);
        sc_config_t cfg;
        cfg.dac_code = dac;
        // Test capacitor on in ctest mode and in the 64-channel sweep
        if (p.inject == inject_ctest || p.all_channels) begin
            cfg.ctest_chn = 64'd1 << ch;
        end else begin
            cfg.ctest_chn = '0;
        end
        // Three discriminators of the channel under test
        cfg.discri_mask = 192'd7 << (3 * ch);
        return cfg;
    endfunction

    ////////////////////
    // Start edge
    ////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            start_d1 <= 1'b0;
            start_d2 <= 1'b0;
        end else begin
            start_d1 <= test_start;
            start_d2 <= start_d1;
        end
    end

    assign start_pulse = start_d1 & ~start_d2;

    // Loop bounds
    assign dac_next   = {1'b0, dac_code} + {1'b0, `SCURVE_DAC_STEP};
    assign last_point = (dac_next > {1'b0, `SCURVE_DAC_LAST});
    assign last_chn   = !param_q.all_channels || (chn == 6'd63);
    // Count word is in the FIFO once it is non-empty
    assign point_done = !fifo_empty;

    assign cpt_max = param_q.cpt_max;

    ////////////////////
    // Sequencer
    ////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state             <= ctrl_idle;
            param_q           <= '0;
            chn               <= '0;
            dac_code          <= '0;
            sc_config         <= '0;
            usb_wr_data       <= '0;
            single_test_start <= 1'b0;
            fifo_clear        <= 1'b0;
            fifo_rd_en        <= 1'b0;
            sc_param_load     <= 1'b0;
            usb_wr_en         <= 1'b0;
            scurve_test_done  <= 1'b0;
        end else begin
            // Strobes default low
            single_test_start <= 1'b0;
            fifo_clear        <= 1'b0;
            fifo_rd_en        <= 1'b0;
            sc_param_load     <= 1'b0;
            usb_wr_en         <= 1'b0;
            scurve_test_done  <= 1'b0;
            case (state)
                // Starts while busy are ignored
                ctrl_idle: begin
                    if (start_pulse) begin
                        param_q    <= test_param;
                        chn        <= test_param.all_channels ? 6'd0 : test_param.single_chn;
                        fifo_clear <= 1'b1;
                        state      <= ctrl_clear;
                    end
                end
                // Channel header, first DAC point
                ctrl_clear: begin
                    usb_wr_en   <= 1'b1;
                    usb_wr_data <= `SCURVE_CHN_HEADER | {10'd0, chn};
                    dac_code    <= `SCURVE_DAC_FIRST;
                    state       <= ctrl_load;
                end
                ctrl_load: begin
                    sc_param_load <= 1'b1;
                    sc_config     <= build_config(chn, dac_code, param_q);
                    state         <= ctrl_wait_config;
                end
                ctrl_wait_config: begin
                    if (microroc_config_done) begin
                        single_test_start <= 1'b1;
                        state             <= ctrl_measure;
                    end
                end
                // Pop and DAC word in one cycle
                ctrl_measure: begin
                    if (point_done) begin
                        fifo_rd_en  <= 1'b1;
                        usb_wr_en   <= 1'b1;
                        usb_wr_data <= {6'd0, dac_code};
                        state       <= ctrl_forward;
                    end
                end
                // Head word still valid, pop lands on this edge
                ctrl_forward: begin
                    usb_wr_en   <= 1'b1;
                    usb_wr_data <= fifo_dout;
                    if (!last_point) begin
                        dac_code <= dac_next[9:0];
                        state    <= ctrl_load;
                    end else if (!last_chn) begin
                        chn   <= chn + 1'b1;
                        state <= ctrl_clear;
                    end else begin
                        state <= ctrl_tail;
                    end
                end
                ctrl_tail: begin
                    usb_wr_en   <= 1'b1;
                    usb_wr_data <= `SCURVE_TAIL_WORD;
                    state       <= ctrl_wait_transmit;
                end
                ctrl_wait_transmit: begin
                    if (data_transmit_done) begin
                        scurve_test_done <= 1'b1;
                        state            <= ctrl_done;
                    end
                end
                // Done strobe is high here
                ctrl_done: state <= ctrl_idle;
                default:   state <= ctrl_idle;
            endcase
        end
    end

endmodule

//--- rtl/scurve_test_top.sv
`timescale 1ns/1ps

module scurve_test_top import microroc_sc_pkg::*, scurve_test_pkg::*; (
    input  logic        Clk,
    input  logic        reset_n,
    // Test control
    input  logic        test_start,
    input  test_param_t test_param,
    // Chip pins
    input  logic        clk_ext,
    input  logic [2:0]  trigger_n,
    // Slow-control loader
    input  logic        microroc_config_done,
    output logic        sc_param_load,
    output sc_config_t  sc_config,
    // USB stream
    output logic        usb_wr_en,
    output logic [15:0] usb_wr_data,
    input  logic        data_transmit_done,
    output logic        scurve_test_done
);
    ////////////////////
    // Internal links
    ////////////////////

    // Control to measurement
    logic        single_test_start;
    logic [15:0] cpt_max;
    // Measurement to FIFO and control
    logic [15:0] count_data;
    logic        count_wr_en;
    logic        single_test_done;
    // FIFO and control
    logic        fifo_empty;
    logic [15:0] fifo_dout;
    logic        fifo_rd_en;
    logic        fifo_clear;

    // Sequencer and USB word builder
    scurve_test_control scurve_test_control_inst (
        .Clk                  (Clk),
        .reset_n              (reset_n),
        .test_start           (test_start),
        .test_param           (test_param),
        .microroc_config_done (microroc_config_done),
        .data_transmit_done   (data_transmit_done),
        .single_test_done     (single_test_done),
        .fifo_empty           (fifo_empty),
        .fifo_dout            (fifo_dout),
        .single_test_start    (single_test_start),
        .cpt_max              (cpt_max),
        .fifo_clear           (fifo_clear),
        .fifo_rd_en           (fifo_rd_en),
        .sc_param_load        (sc_param_load),
        .sc_config            (sc_config),
        .usb_wr_en            (usb_wr_en),
        .usb_wr_data          (usb_wr_data),
        .scurve_test_done     (scurve_test_done)
    );

    // Trigger counter for one DAC point
    scurve_single_test scurve_single_test_inst (
        .Clk               (Clk),
        .reset_n           (reset_n),
        .clk_ext           (clk_ext),
        .trigger_n         (trigger_n),
        .single_test_start (single_test_start),
        .cpt_max           (cpt_max),
        .count_data        (count_data),
        .count_wr_en       (count_wr_en),
        .single_test_done  (single_test_done)
    );

    // Count buffer, one word per point, full never reached
    scurve_data_fifo scurve_data_fifo_inst (
        .Clk     (Clk),
        .reset_n (reset_n),
        .clear   (fifo_clear),
        .wr_en   (count_wr_en),
        .din     (count_data),
        .rd_en   (fifo_rd_en),
        .dout    (fifo_dout),
        .empty   (fifo_empty),
        .full    ()
    );

endmodule

//--- testbench/tb_scurve_test_top.sv
`timescale 1ns/1ps
`include "scurve_settings.svh"

module tb_scurve_test_top import microroc_sc_pkg::*, scurve_test_pkg::*; ();
    localparam int DAC_FIRST = int'(`SCURVE_DAC_FIRST);
    localparam int DAC_LAST  = int'(`SCURVE_DAC_LAST);
    localparam int DAC_STEP  = int'(`SCURVE_DAC_STEP);
    localparam int NPOINTS   = (DAC_LAST - DAC_FIRST) / DAC_STEP + 1;

    logic        Clk;
    logic        reset_n;
    logic        test_start;
    test_param_t test_param;
    logic        clk_ext;
    logic [2:0]  trigger_n;
    logic        microroc_config_done;
    logic        data_transmit_done;
    logic        sc_param_load;
    sc_config_t  sc_config;
    logic        usb_wr_en;
    logic [15:0] usb_wr_data;
    logic        scurve_test_done;

    integer      seed = 55611;
    int          mismatch_count = 0;
    int          event_count = 0;
    int          done_pulses = 0;
    logic        transmit_seen = 1'b0;
    longint      watchdog_ns = 0;
    test_param_t cur_param;
    // Expected loads, recorded trigger counts, captured stream
    sc_config_t  exp_cfgs[$];
    int          k_queue[$];
    logic [15:0] usb_words[$];

    scurve_test_top scurve_test_top_inst (
        .Clk(Clk), .reset_n(reset_n), .test_start(test_start), .test_param(test_param),
        .clk_ext(clk_ext), .trigger_n(trigger_n),
        .microroc_config_done(microroc_config_done), .sc_param_load(sc_param_load),
        .sc_config(sc_config), .usb_wr_en(usb_wr_en), .usb_wr_data(usb_wr_data),
        .data_transmit_done(data_transmit_done), .scurve_test_done(scurve_test_done)
    );

    // 4 ns system clock, 40 ns chip clock, edges line up on Clk falls
    always #2 Clk = ~Clk;
    always #20 clk_ext = ~clk_ext;

    ////////////////////
    // Helpers and model
    ////////////////////

    function automatic int draw_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic test_param_t random_param(input logic all, input int cpt_min,
                                                 input int cpt_span);
        test_param_t p;
        p.single_chn   = 6'(draw_below(64));
        p.all_channels = all;
        p.inject       = (draw_below(2) == 1) ? inject_input : inject_ctest;
        p.cpt_max      = 16'(cpt_min + draw_below(cpt_span));
        return p;
    endfunction

    // Expected config from the ctest and discriminator rules
    function automatic sc_config_t expected_config(input int ch, input int dac,
                                                   input test_param_t p);
        sc_config_t cfg;
        cfg          = '0;
        cfg.dac_code = 10'(dac);
        if (p.all_channels || p.inject == inject_ctest) begin
            cfg.ctest_chn = 64'd1 << ch;
        end
        for (int b = 0; b < 3; b++) begin
            cfg.discri_mask = cfg.discri_mask | (192'd1 << (3 * ch + b));
        end
        return cfg;
    endfunction

    task automatic compare_usb_word(input logic [15:0] exp, input logic [15:0] act,
                                    input int idx);
        if (exp !== act) begin
            mismatch_count++;
            $display("mismatch at %0t: usb_wr_data word %0d expected %h actual %h",
                     $time, idx, exp, act);
        end
    endtask

    task automatic compare_sc_config(input sc_config_t exp, input sc_config_t act);
        if (exp !== act) begin
            mismatch_count++;
            $display("mismatch at %0t: sc_config expected %h actual %h", $time, exp, act);
        end
    endtask

    task automatic compare_done(input int exp, input int act);
        if (exp != act) begin
            mismatch_count++;
            $display("mismatch at %0t: scurve_test_done pulses expected %0d actual %0d",
                     $time, exp, act);
        end
    endtask

    // Pulses on idle trigger lines that no count may include
    task automatic stray_triggers(input int n);
        repeat (n) begin
            trigger_n = ~(3'b001 << draw_below(3));
            repeat (3) @(negedge Clk);
            trigger_n = 3'b111;
            repeat (5) @(negedge Clk);
        end
    endtask

    ////////////////////
    // One full test
    ////////////////////

    task automatic run_test(input test_param_t p);
        int          chans[$];
        logic [15:0] exp_words[$];
        int          start_pulses;
        int          kval;
        if (p.all_channels) begin
            for (int c = 0; c < 64; c++) chans.push_back(c);
        end else begin
            chans.push_back(int'(p.single_chn));
        end
        cur_param = p;
        exp_cfgs.delete();
        k_queue.delete();
        usb_words.delete();
        transmit_seen = 1'b0;
        foreach (chans[i]) begin
            for (int d = DAC_FIRST; d <= DAC_LAST; d += DAC_STEP) begin
                exp_cfgs.push_back(expected_config(chans[i], d, p));
            end
        end
        start_pulses = done_pulses;
        test_param   = p;
        test_start   = 1'b1;
        repeat (4) @(negedge Clk);
        // Captured values must hold while the inputs move on
        test_start = 1'b0;
        test_param = random_param(1'b1, 4, 100);
        // Second edge during the run
        repeat (100) @(negedge Clk);
        test_start = 1'b1;
        repeat (4) @(negedge Clk);
        test_start = 1'b0;
        wait (done_pulses != start_pulses);
        // Room for a stray second done pulse
        repeat (20) @(negedge Clk);
        compare_done(1, done_pulses - start_pulses);

        // Header, DAC and count pairs, tail
        foreach (chans[i]) begin
            exp_words.push_back({8'hFF, 8'(chans[i])});
            for (int d = DAC_FIRST; d <= DAC_LAST; d += DAC_STEP) begin
                exp_words.push_back(16'(d));
                kval = 0;
                if (k_queue.size() == 0) begin
                    event_count++;
                    $display("no trigger count recorded for channel %0d code %0d", chans[i], d);
                end else begin
                    kval = k_queue.pop_front();
                end
                exp_words.push_back(16'(kval));
            end
        end
        exp_words.push_back(`SCURVE_TAIL_WORD);
        if (usb_words.size() != exp_words.size()) begin
            event_count++;
            $display("usb stream has %0d words, expected %0d", usb_words.size(), exp_words.size());
        end
        for (int i = 0; i < exp_words.size() && i < usb_words.size(); i++) begin
            compare_usb_word(exp_words[i], usb_words[i], i);
        end
        if (exp_cfgs.size() != 0) begin
            event_count++;
            $display("%0d slow-control loads never happened", exp_cfgs.size());
        end
    endtask

    ////////////////////
    // Stand-ins
    ////////////////////

    // Loader answers each load, then triggers fire inside the window
    initial begin : loader_and_triggers
        int delay;
        int k;
        forever begin
            @(negedge Clk);
            if (reset_n && sc_param_load) begin
                if (exp_cfgs.size() == 0) begin
                    event_count++;
                    $display("unexpected sc_param_load at %0t", $time);
                end else begin
                    compare_sc_config(exp_cfgs.pop_front(), sc_config);
                end
                delay = 1 + draw_below(20);
                repeat (delay) @(negedge Clk);
                microroc_config_done = 1'b1;
                @(negedge Clk);
                microroc_config_done = 1'b0;
                // Two chip clock periods, then one pulse per period
                repeat (20) @(negedge Clk);
                k = draw_below(int'(cur_param.cpt_max) - 3);
                repeat (k) begin
                    repeat (5) @(negedge Clk);
                    trigger_n = ~(3'b001 << draw_below(3));
                    repeat (3) @(negedge Clk);
                    trigger_n = 3'b111;
                    repeat (2) @(negedge Clk);
                end
                k_queue.push_back(k);
            end
        end
    end

    // USB side acknowledges the tail
    initial begin : usb_side
        int delay;
        forever begin
            @(negedge Clk);
            if (reset_n && usb_wr_en && usb_wr_data == `SCURVE_TAIL_WORD) begin
                delay = 1 + draw_below(16);
                repeat (delay) @(negedge Clk);
                data_transmit_done = 1'b1;
                transmit_seen      = 1'b1;
                @(negedge Clk);
                data_transmit_done = 1'b0;
            end
        end
    end

    // Stream capture and done ordering
    always @(negedge Clk) begin
        if (reset_n) begin
            if (usb_wr_en) usb_words.push_back(usb_wr_data);
            if (scurve_test_done) begin
                done_pulses++;
                if (!transmit_seen) begin
                    event_count++;
                    $display("scurve_test_done at %0t came before data_transmit_done", $time);
                end
            end
        end
    end

    initial begin : watchdog
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, a test never finished", watchdog_ns);
        $display("*** FAILED ***");
        $finish;
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin : main
        test_param_t tests[4];
        longint      budget;
        Clk = 1'b0;
        clk_ext = 1'b0;
        reset_n = 1'b0;
        test_start = 1'b0;
        test_param = '0;
        trigger_n = 3'b111;
        microroc_config_done = 1'b0;
        data_transmit_done = 1'b0;
        tests[0] = random_param(1'b0, 8, 8);
        tests[0].inject = inject_ctest;
        tests[1] = random_param(1'b0, 4, 12);
        tests[1].inject = inject_input;
        // Short window for the 64-channel sweep
        tests[2] = random_param(1'b1, 6, 1);
        tests[3] = random_param(1'b0, 4, 16);
        budget = 20000;
        foreach (tests[i]) begin
            budget += longint'(tests[i].all_channels ? 64 : 1) * NPOINTS
                      * (longint'(tests[i].cpt_max) + 30) * 40;
        end
        watchdog_ns = budget;
        repeat (8) @(negedge Clk);
        reset_n = 1'b1;
        stray_triggers(5);
        foreach (tests[i]) begin
            run_test(tests[i]);
            stray_triggers(3);
        end
        $display("errors: %0d mismatches, %0d event errors", mismatch_count, event_count);
        if (mismatch_count == 0 && event_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/microroc_sc_pkg.sv
rtl/scurve_test_pkg.sv
rtl/scurve_data_fifo.sv
rtl/scurve_single_test.sv
rtl/scurve_test_control.sv
rtl/scurve_test_top.sv
testbench/tb_scurve_test_top.sv

//--- Makefile
# Verilator build and run of the S-curve engine testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		--top-module tb_scurve_test_top --Mdir obj_dir -o sim_tb -f filelist.f
	./obj_dir/sim_tb | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
